/* include/dma_config.svh */
//##########################################################################
// channel and engine build constants
// FIFO depth is 2**DMA_FIFO_AW words, one clock domain
// the almost margin must cover the two words in flight in the engine
// register offsets are byte addresses on a 4-bit APB address
//##########################################################################
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// fifo geometry
`define DMA_FIFO_AW     4
`define DMA_ALMOST_LVL  2

// apb register map
`define DMA_REG_CTRL    4'h0
`define DMA_REG_KEY_LO  4'h4
`define DMA_REG_KEY_HI  4'h8
`define DMA_REG_STATUS  4'hC

`endif

/* hw/dma_pkg.sv */
//##########################################################################
// types shared by the channel and the engine stages
// a FIFO entry is 65 bits with the last flag on top
// CTRL holds enable in bit 0 and the operation in bits 2:1
//##########################################################################
`default_nettype none

package dma_pkg;

   // one channel word as stored in either FIFO
   typedef struct packed
   {
      logic        last;     // final word of a burst
      logic [31:0] hi;       // bus dat64 half
      logic [31:0] lo;       // bus dat half
   } chan_word_t;

   // transform selected in CTRL
   typedef enum logic [1:0]
   {
      OP_PASS  = 2'd0,
      OP_XOR   = 2'd1,
      OP_ADD32 = 2'd2,
      OP_BSWAP = 2'd3
   } op_e;

   // CTRL register layout
   typedef struct packed
   {
      op_e  op;
      logic enable;
   } ctrl_reg_t;

endpackage

`default_nettype wire

/* hw/fifo_if.sv */
//##########################################################################
// push/pop bundle of one channel FIFO
// pop_word shows the head word whenever empty is low
// the FIFO owner drives the flags through a plain interface port
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

interface fifo_if;
   logic                push;
   dma_pkg::chan_word_t push_word;
   logic                pop;
   dma_pkg::chan_word_t pop_word;     // first-word fall-through
   logic                empty;
   logic                almost_empty;
   logic                half_full;
   logic                almost_full;
   logic                full;

   modport writer (output push, output push_word, input full, input almost_full);

   modport reader (output pop, input pop_word, input empty, input almost_empty);
endinterface

`default_nettype wire

/* hw/chan_fifo.sv */
//##########################################################################
// synchronous FIFO of chan_word_t entries, single clock
// push when full and pop when empty are ignored
// flags are registered and follow the count of the same edge
// storage has no reset, so the head word is undefined while empty
//##########################################################################
`timescale 1ns/100ps
`default_nettype none
`include "dma_config.svh"

module chan_fifo
(
   input  wire wb_clk_i,
   input  wire m_reset,
   fifo_if     wr,        // push side
   fifo_if     rd         // pop side
);
   localparam int DEPTH = 1 << `DMA_FIFO_AW;
   localparam int CW    = `DMA_FIFO_AW + 1;

   dma_pkg::chan_word_t     mem [DEPTH];
   logic [`DMA_FIFO_AW-1:0] wr_ptr;
   logic [`DMA_FIFO_AW-1:0] rd_ptr;
   logic [CW-1:0]           count;
   logic [CW-1:0]           count_nxt;
   logic                    do_push;
   logic                    do_pop;

   assign do_push = wr.push & ~wr.full;
   assign do_pop  = rd.pop & ~rd.empty;

   assign rd.pop_word = mem[rd_ptr];   // head word, no read latency

   // occupancy after this edge
   always_comb
   begin
      count_nxt = count;
      if (do_push & ~do_pop)
         count_nxt = count + 1'b1;
      else if (do_pop & ~do_push)
         count_nxt = count - 1'b1;
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (do_push)
         mem[wr_ptr] <= wr.push_word;
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count_nxt;
      end
   end

   // level flags
   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
      begin
         rd.empty        <= 1'b1;
         rd.almost_empty <= 1'b1;
         rd.half_full    <= 1'b0;
         wr.almost_full  <= 1'b0;
         wr.full         <= 1'b0;
      end
      else
      begin
         rd.empty        <= (count_nxt == '0);
         rd.almost_empty <= (count_nxt <= CW'(`DMA_ALMOST_LVL));
         rd.half_full    <= (count_nxt >= CW'(DEPTH / 2));
         wr.almost_full  <= (count_nxt >= CW'(DEPTH - `DMA_ALMOST_LVL));
         wr.full         <= (count_nxt == CW'(DEPTH));
      end
   end
endmodule

`default_nettype wire

/* hw/dma_channel.sv */
//##########################################################################
// stream channel with source and destination FIFOs
// a last word is never popped by dst_xfer_i, it stays at the head
// ocnt_o counts accepted non-last destination words since reset
// start/stop/end are pacing hints only, writes when full are lost
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

module dma_channel
(
   input  wire         wb_clk_i,
   input  wire         m_reset,
   input  wire         src_xfer_i,
   input  wire         src_last_i,
   input  wire  [31:0] src_dat_i,
   input  wire  [31:0] src_dat64_i,
   input  wire         dst_xfer_i,
   output logic        src_stop_o,
   output logic        src_start_o,
   output logic        dst_stop_o,
   output logic        dst_start_o,
   output logic        dst_end_o,
   output logic [31:0] dst_dat_o,
   output logic [31:0] dst_dat64_o,
   fifo_if             src_rd,      // engine pops this one
   fifo_if             dst_wr,      // engine pushes this one
   input  wire         done_i,
   output logic [15:0] ocnt_o
);
   logic dst_head_last;

   chan_fifo u_src_fifo
   (
      .wb_clk_i (wb_clk_i),
      .m_reset  (m_reset),
      .wr       (src_rd),
      .rd       (src_rd)
   );

   chan_fifo u_dst_fifo
   (
      .wb_clk_i (wb_clk_i),
      .m_reset  (m_reset),
      .wr       (dst_wr),
      .rd       (dst_wr)
   );

   // bus side into the source FIFO
   assign src_rd.push      = src_xfer_i;
   assign src_rd.push_word = '{last: src_last_i, hi: src_dat64_i, lo: src_dat_i};

   // destination head onto the bus
   assign dst_head_last = ~dst_wr.empty & dst_wr.pop_word.last;
   assign dst_wr.pop    = dst_xfer_i & ~dst_head_last;   // hold the last word
   assign dst_dat_o     = dst_wr.pop_word.lo;
   assign dst_dat64_o   = dst_wr.pop_word.hi;

   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
         ocnt_o <= 16'h0;
      else if (dst_wr.push & ~dst_wr.full & ~dst_wr.push_word.last)
         ocnt_o <= ocnt_o + 1'b1;
   end

   // pacing hints
   assign src_stop_o  = src_rd.almost_full;
   assign src_start_o = ~src_rd.half_full;         // room for a burst
   assign dst_stop_o  = dst_wr.almost_empty;
   assign dst_start_o = dst_wr.half_full | (done_i & ~dst_wr.empty);
   assign dst_end_o   = dst_head_last;
endmodule

`default_nettype wire

/* hw/xfer_decode.sv */
//##########################################################################
// APB register file and issue stage
// no wait states and no slave error, pready_o is always high
// a pop is issued only while the destination is below almost full
//##########################################################################
`timescale 1ns/100ps
`default_nettype none
`include "dma_config.svh"

module xfer_decode
(
   input  wire                 wb_clk_i,
   input  wire                 m_reset,
   input  wire  [3:0]          paddr_i,
   input  wire                 psel_i,
   input  wire                 penable_i,
   input  wire                 pwrite_i,
   input  wire  [31:0]         pwdata_i,
   output logic [31:0]         prdata_o,
   output logic                pready_o,
   input  wire  [15:0]         ocnt_i,
   input  wire                 done_i,
   fifo_if.reader              src_rd,
   input  wire                 dst_almost_full_i,
   output logic                issue_o,
   output dma_pkg::chan_word_t issue_word_o,
   output dma_pkg::op_e        op_o,
   output logic [63:0]         key_o,
   output logic                start_o
);
   dma_pkg::ctrl_reg_t ctrl_q;
   logic [31:0]        key_lo_q;
   logic [31:0]        key_hi_q;
   logic               apb_wr;

   assign apb_wr   = psel_i & penable_i & pwrite_i;   // access phase write
   assign pready_o = 1'b1;

   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
      begin
         ctrl_q   <= '0;
         key_lo_q <= '0;
         key_hi_q <= '0;
      end
      else if (apb_wr)
      begin
         case (paddr_i)
            `DMA_REG_CTRL:
            begin
               ctrl_q.enable <= pwdata_i[0];
               ctrl_q.op     <= dma_pkg::op_e'(pwdata_i[2:1]);
            end
            `DMA_REG_KEY_LO: key_lo_q <= pwdata_i;
            `DMA_REG_KEY_HI: key_hi_q <= pwdata_i;
            default: ;                 // STATUS is read only
         endcase
      end
   end

   // read mux
   always_comb
   begin
      prdata_o = '0;
      if (psel_i & ~pwrite_i)
      begin
         case (paddr_i)
            `DMA_REG_CTRL:   prdata_o = {29'b0, ctrl_q};
            `DMA_REG_KEY_LO: prdata_o = key_lo_q;
            `DMA_REG_KEY_HI: prdata_o = key_hi_q;
            `DMA_REG_STATUS: prdata_o = {15'b0, done_i, ocnt_i};
            default:         prdata_o = '0;
         endcase
      end
   end

   assign start_o = apb_wr & (paddr_i == `DMA_REG_CTRL) & pwdata_i[0];

   // issue
   assign issue_o      = ctrl_q.enable & ~src_rd.empty & ~dst_almost_full_i;
   assign src_rd.pop   = issue_o;
   assign issue_word_o = src_rd.pop_word;
   assign op_o         = ctrl_q.op;
   assign key_o        = {key_hi_q, key_lo_q};
endmodule

`default_nettype wire

/* hw/xfer_execute.sv */
//##########################################################################
// execute stage, one register
// op and key are sampled with the word, a change mid-stream
// applies from the next issued word on
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

module xfer_execute
(
   input  wire                 wb_clk_i,
   input  wire                 m_reset,
   input  wire                 issue_i,
   input  dma_pkg::chan_word_t issue_word_i,
   input  dma_pkg::op_e        op_i,
   input  wire  [63:0]         key_i,
   output logic                exe_valid_o,
   output dma_pkg::chan_word_t exe_word_o
);
   dma_pkg::chan_word_t res;
   logic [63:0]         data_in;
   logic [63:0]         swapped;

   assign data_in = {issue_word_i.hi, issue_word_i.lo};

   // byte 0 goes to byte 7 and so on
   always_comb
   begin
      for (int b = 0; b < 8; b++)
         swapped[8*b +: 8] = data_in[56-8*b +: 8];
   end

   always_comb
   begin
      res = issue_word_i;              // last flag rides along
      case (op_i)
         dma_pkg::OP_XOR:
         begin
            res.hi = issue_word_i.hi ^ key_i[63:32];
            res.lo = issue_word_i.lo ^ key_i[31:0];
         end
         dma_pkg::OP_ADD32:
         begin
            res.hi = issue_word_i.hi + key_i[63:32];   // no carry between lanes
            res.lo = issue_word_i.lo + key_i[31:0];
         end
         dma_pkg::OP_BSWAP:
         begin
            res.hi = swapped[63:32];
            res.lo = swapped[31:0];
         end
         default: res = issue_word_i;  // pass
      endcase
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
         exe_valid_o <= 1'b0;
      else
         exe_valid_o <= issue_i;
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (issue_i)
         exe_word_o <= res;
   end
endmodule

`default_nettype wire

/* hw/xfer_result.sv */
//##########################################################################
// write-back stage into the destination FIFO
// done is set by an accepted last word and cleared by start_i
// start_i wins when both happen on one edge
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

module xfer_result
(
   input  wire                 wb_clk_i,
   input  wire                 m_reset,
   input  wire                 start_i,
   input  wire                 exe_valid_i,
   input  dma_pkg::chan_word_t exe_word_i,
   fifo_if.writer              dst_wr,
   output logic                done_o
);
   logic                push_q;
   dma_pkg::chan_word_t word_q;

   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
         push_q <= 1'b0;
      else
         push_q <= exe_valid_i;
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (exe_valid_i)
         word_q <= exe_word_i;   // payload
   end

   assign dst_wr.push      = push_q;
   assign dst_wr.push_word = word_q;

   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset | start_i)
         done_o <= 1'b0;
      else if (push_q & word_q.last & ~dst_wr.full)
         done_o <= 1'b1;         // burst landed
   end
endmodule

`default_nettype wire

/* hw/dma_engine_top.sv */
//##########################################################################
// one-channel transform engine, APB config plus bus-side stream ports
// everything on wb_clk_i with synchronous m_reset
// pop to push latency is 2 cycles, at most two words in flight
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

module dma_engine_top
(
   input  wire         wb_clk_i,
   input  wire         m_reset,
   input  wire  [3:0]  paddr_i,
   input  wire         psel_i,
   input  wire         penable_i,
   input  wire         pwrite_i,
   input  wire  [31:0] pwdata_i,
   output logic [31:0] prdata_o,
   output logic        pready_o,
   input  wire         src_xfer_i,
   input  wire         src_last_i,
   input  wire  [31:0] src_dat_i,
   input  wire  [31:0] src_dat64_i,
   input  wire         dst_xfer_i,
   output logic        src_stop_o,
   output logic        src_start_o,
   output logic        dst_stop_o,
   output logic        dst_start_o,
   output logic        dst_end_o,
   output logic [31:0] dst_dat_o,
   output logic [31:0] dst_dat64_o
);
   logic [15:0]         ocnt;
   logic                done;
   logic                start;
   logic                issue;
   dma_pkg::chan_word_t issue_word;
   dma_pkg::op_e        op;
   logic [63:0]         key;
   logic                exe_valid;
   dma_pkg::chan_word_t exe_word;

   fifo_if src_if ();
   fifo_if dst_if ();

   dma_channel u_channel
   (
      .wb_clk_i    (wb_clk_i),
      .m_reset     (m_reset),
      .src_xfer_i  (src_xfer_i),
      .src_last_i  (src_last_i),
      .src_dat_i   (src_dat_i),
      .src_dat64_i (src_dat64_i),
      .dst_xfer_i  (dst_xfer_i),
      .src_stop_o  (src_stop_o),
      .src_start_o (src_start_o),
      .dst_stop_o  (dst_stop_o),
      .dst_start_o (dst_start_o),
      .dst_end_o   (dst_end_o),
      .dst_dat_o   (dst_dat_o),
      .dst_dat64_o (dst_dat64_o),
      .src_rd      (src_if),
      .dst_wr      (dst_if),
      .done_i      (done),
      .ocnt_o      (ocnt)
   );

   xfer_decode u_decode
   (
      .wb_clk_i          (wb_clk_i),
      .m_reset           (m_reset),
      .paddr_i           (paddr_i),
      .psel_i            (psel_i),
      .penable_i         (penable_i),
      .pwrite_i          (pwrite_i),
      .pwdata_i          (pwdata_i),
      .prdata_o          (prdata_o),
      .pready_o          (pready_o),
      .ocnt_i            (ocnt),
      .done_i            (done),
      .src_rd            (src_if),
      .dst_almost_full_i (dst_if.almost_full),
      .issue_o           (issue),
      .issue_word_o      (issue_word),
      .op_o              (op),
      .key_o             (key),
      .start_o           (start)
   );

   xfer_execute u_execute
   (
      .wb_clk_i     (wb_clk_i),
      .m_reset      (m_reset),
      .issue_i      (issue),
      .issue_word_i (issue_word),
      .op_i         (op),
      .key_i        (key),
      .exe_valid_o  (exe_valid),
      .exe_word_o   (exe_word)
   );

   xfer_result u_result
   (
      .wb_clk_i    (wb_clk_i),
      .m_reset     (m_reset),
      .start_i     (start),
      .exe_valid_i (exe_valid),
      .exe_word_i  (exe_word),
      .dst_wr      (dst_if),
      .done_o      (done)
   );
endmodule

`default_nettype wire

/* verification/dma_engine_tb.sv */
//##########################################################################
// testbench for dma_engine_top, one clock, every test starts from reset
// a last word is never popped, it stays at the destination head
// stimulus from an LCG, expected words from a reference model
//##########################################################################
`timescale 1ns/100ps
`default_nettype none
`include "dma_config.svh"

module dma_engine_tb;
   localparam int TOTAL_WORDS     = 12 + 8 + 8 + 8 + 18 + 40;
   localparam int WATCHDOG_CYCLES = 40 * TOTAL_WORDS + 2000;

   logic        wb_clk_i;
   logic        m_reset;
   logic [3:0]  paddr_i;
   logic        psel_i;
   logic        penable_i;
   logic        pwrite_i;
   logic [31:0] pwdata_i;
   logic [31:0] prdata_o;
   logic        pready_o;
   logic        src_xfer_i;
   logic        src_last_i;
   logic [31:0] src_dat_i;
   logic [31:0] src_dat64_i;
   logic        dst_xfer_i;
   logic        src_stop_o;
   logic        src_start_o;
   logic        dst_stop_o;
   logic        dst_start_o;
   logic        dst_end_o;
   logic [31:0] dst_dat_o;
   logic [31:0] dst_dat64_o;

   logic [31:0]         rng_state;
   dma_pkg::op_e        cur_op;
   logic [63:0]         cur_key;
   dma_pkg::chan_word_t exp_q[$];   // expected destination words, in order

   dma_engine_top uut
   (
      .wb_clk_i    (wb_clk_i),
      .m_reset     (m_reset),
      .paddr_i     (paddr_i),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .src_xfer_i  (src_xfer_i),
      .src_last_i  (src_last_i),
      .src_dat_i   (src_dat_i),
      .src_dat64_i (src_dat64_i),
      .dst_xfer_i  (dst_xfer_i),
      .src_stop_o  (src_stop_o),
      .src_start_o (src_start_o),
      .dst_stop_o  (dst_stop_o),
      .dst_start_o (dst_start_o),
      .dst_end_o   (dst_end_o),
      .dst_dat_o   (dst_dat_o),
      .dst_dat64_o (dst_dat64_o)
   );

   initial
   begin
      wb_clk_i = 1'b0;
      forever #10 wb_clk_i = ~wb_clk_i;
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic dma_pkg::chan_word_t rand_word(input logic last);
      dma_pkg::chan_word_t w;
      w.lo   = lcg_next();
      w.hi   = lcg_next();
      w.last = last;
      return w;
   endfunction

   // expected engine output for one source word
   function automatic dma_pkg::chan_word_t ref_transform(input dma_pkg::op_e op,
                                                         input logic [63:0] key,
                                                         input dma_pkg::chan_word_t w);
      dma_pkg::chan_word_t r;
      logic [63:0]         d;
      r = w;
      d = {w.hi, w.lo};
      case (op)
         dma_pkg::OP_XOR:
            d = d ^ key;
         dma_pkg::OP_ADD32:
         begin
            r.hi = w.hi + key[63:32];   // lane carry is dropped
            r.lo = w.lo + key[31:0];
            d    = {r.hi, r.lo};
         end
         dma_pkg::OP_BSWAP:
            d = {d[7:0], d[15:8], d[23:16], d[31:24], d[39:32], d[47:40], d[55:48], d[63:56]};
         default: ;
      endcase
      r.hi = d[63:32];
      r.lo = d[31:0];
      return r;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_word(input dma_pkg::chan_word_t got, input dma_pkg::chan_word_t exp);
      if (got !== exp)
         stop_on_error($sformatf("destination word %0b_%h_%h, expected %0b_%h_%h",
                                 got.last, got.hi, got.lo, exp.last, exp.hi, exp.lo));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_on_error($sformatf("%s is %0b, expected %0b", name, got, exp));
   endtask

   task automatic check_status(input logic [31:0] got, input logic [15:0] exp_cnt,
                               input logic exp_done);
      if (got !== {15'b0, exp_done, exp_cnt})
         stop_on_error($sformatf("STATUS is %h, expected count %0d done %0b",
                                 got, exp_cnt, exp_done));
   endtask

   // every driver step ends 2 ns after a rising edge
   task automatic next_cycle();
      @(posedge wb_clk_i);
      #2;
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
      paddr_i   = addr;
      pwdata_i  = data;
      pwrite_i  = 1'b1;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      next_cycle();
      penable_i = 1'b1;
      check_flag("pready_o", pready_o, 1'b1);
      next_cycle();
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
      paddr_i   = addr;
      pwrite_i  = 1'b0;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      next_cycle();
      penable_i = 1'b1;
      check_flag("pready_o", pready_o, 1'b1);
      data = prdata_o;             // access phase
      next_cycle();
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic expect_status(input logic [15:0] exp_cnt, input logic exp_done);
      logic [31:0] st;
      apb_read(`DMA_REG_STATUS, st);
      check_status(st, exp_cnt, exp_done);
   endtask

   task automatic configure(input dma_pkg::op_e op, input logic [63:0] key);
      dma_pkg::ctrl_reg_t c;
      cur_op   = op;
      cur_key  = key;
      c.enable = 1'b1;
      c.op     = op;
      apb_write(`DMA_REG_KEY_LO, key[31:0]);
      apb_write(`DMA_REG_KEY_HI, key[63:32]);
      apb_write(`DMA_REG_CTRL, {29'b0, c});
   endtask

   task automatic apply_reset();
      m_reset = 1'b1;
      repeat (4) @(posedge wb_clk_i);
      #2;
      m_reset = 1'b0;
      exp_q.delete();
      check_flag("src_stop_o", src_stop_o, 1'b0);
      check_flag("src_start_o", src_start_o, 1'b1);
      check_flag("dst_start_o", dst_start_o, 1'b0);
      check_flag("dst_end_o", dst_end_o, 1'b0);
      expect_status(16'd0, 1'b0);
   endtask

   task automatic write_src(input dma_pkg::chan_word_t w);
      src_xfer_i  = 1'b1;
      src_last_i  = w.last;
      src_dat_i   = w.lo;
      src_dat64_i = w.hi;
      next_cycle();
      src_xfer_i  = 1'b0;
   endtask

   // paced by src_stop_o, so no write is dropped
   task automatic send_word(input dma_pkg::chan_word_t w);
      while (src_stop_o)
         next_cycle();
      exp_q.push_back(ref_transform(cur_op, cur_key, w));
      write_src(w);
   endtask

   // pops only with 3 or more words held, so the head is never the last one
   task automatic drain_until_done();
      logic [31:0] st;
      apb_read(`DMA_REG_STATUS, st);
      while (!st[16])
      begin
         dst_xfer_i = ~dst_stop_o;
         next_cycle();
         dst_xfer_i = 1'b0;
         apb_read(`DMA_REG_STATUS, st);
      end
   endtask

   // all words have landed, so the destination holds exactly the queued ones
   task automatic drain_rest();
      while (exp_q.size() > 0)
      begin
         check_flag("dst_start_o", dst_start_o, 1'b1);   // done and words left
         check_flag("dst_stop_o", dst_stop_o, exp_q.size() <= `DMA_ALMOST_LVL);
         dst_xfer_i = 1'b1;
         next_cycle();
      end
      dst_xfer_i = 1'b0;
   endtask

   task automatic run_burst(input dma_pkg::op_e op, input logic [63:0] key,
                            input int n, input logic carry);
      dma_pkg::chan_word_t w;
      apply_reset();
      configure(op, key);
      for (int i = 0; i < n; i++)
      begin
         w = rand_word(i == n - 1);
         if (carry && (i % 2 == 0))
         begin
            w.hi = 32'h1000_0000 | (w.hi & 32'h0fff_ffff);   // lane overflow
            w.lo = 32'hffff_ff00 | (w.lo & 32'h0000_00ff);
         end
         send_word(w);
      end
      drain_until_done();
      expect_status(16'(n - 1), 1'b1);
      drain_rest();
   endtask

   task automatic test_src_flags();
      dma_pkg::chan_word_t w;
      int                  held;
      apply_reset();
      cur_op  = dma_pkg::OP_PASS;
      cur_key = '0;
      held    = 0;
      for (int i = 0; i < 18; i++)
      begin
         w = rand_word(i == 15);
         write_src(w);
         if (held < 16)
         begin
            exp_q.push_back(ref_transform(cur_op, cur_key, w));
            held++;
         end
         check_flag("src_start_o", src_start_o, held < 8);
         check_flag("src_stop_o", src_stop_o, held >= 14);
      end
      configure(dma_pkg::OP_PASS, '0);
      drain_until_done();
      expect_status(16'd15, 1'b1);
      drain_rest();
   endtask

   task automatic test_backpressure();
      apply_reset();
      configure(dma_pkg::OP_XOR, {lcg_next(), lcg_next()});
      fork
         begin
            for (int i = 0; i < 40; i++)
               send_word(rand_word(i == 39));
         end
         begin
            while (!src_stop_o)   // both FIFOs backed up
               next_cycle();
            drain_until_done();
         end
      join
      expect_status(16'd39, 1'b1);
      drain_rest();
   endtask

   // one compare per destination word taken
   always @(negedge wb_clk_i)
   begin : compare_dst
      dma_pkg::chan_word_t got;
      if (!m_reset && dst_xfer_i)
      begin
         got.last = dst_end_o;
         got.hi   = dst_dat64_o;
         got.lo   = dst_dat_o;
         if (exp_q.size() == 0)
            stop_on_error("destination word taken while none was expected");
         else
            check_word(got, exp_q.pop_front());
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge wb_clk_i);
      $display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
      $display("Testbench failed");
      $fatal(1);
   end

   initial
   begin
      rng_state   = 32'h09c9c666;
      m_reset     = 1'b1;
      paddr_i     = 4'h0;
      psel_i      = 1'b0;
      penable_i   = 1'b0;
      pwrite_i    = 1'b0;
      pwdata_i    = 32'h0;
      src_xfer_i  = 1'b0;
      src_last_i  = 1'b0;
      src_dat_i   = 32'h0;
      src_dat64_i = 32'h0;
      dst_xfer_i  = 1'b0;
      cur_op      = dma_pkg::OP_PASS;
      cur_key     = '0;

      run_burst(dma_pkg::OP_PASS, {lcg_next(), lcg_next()}, 12, 1'b0);
      check_flag("dst_start_o", dst_start_o, 1'b1);   // last word still held
      configure(dma_pkg::OP_PASS, cur_key);             // clears done
      expect_status(16'd11, 1'b0);
      check_flag("dst_start_o", dst_start_o, 1'b0);

      run_burst(dma_pkg::OP_XOR, {lcg_next(), lcg_next()}, 8, 1'b0);
      run_burst(dma_pkg::OP_BSWAP, {lcg_next(), lcg_next()}, 8, 1'b0);
      run_burst(dma_pkg::OP_ADD32, 64'hf000_0001_ffff_ff00, 8, 1'b1);
      test_src_flags();
      test_backpressure();

      $display("Testbench passed");
      $finish;
   end
endmodule

`default_nettype wire

/* build.f */
+incdir+include
hw/dma_pkg.sv
hw/fifo_if.sv
hw/chan_fifo.sv
hw/dma_channel.sv
hw/xfer_decode.sv
hw/xfer_execute.sv
hw/xfer_result.sv
hw/dma_engine_top.sv
verification/dma_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dma engine testbench with Verilator
# a failing run ends in $fatal, so the exit status carries the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module dma_engine_tb \
   -Mdir obj_dir \
   -f build.f

./obj_dir/Vdma_engine_tb
